// File: Bender.yml
package:
  name: ps2_keyboard

sources:
  - common/kbd_pkg.sv
  - ps2/ps2_rx.sv
  - ps2/scan_fifo.sv
  - src/key_decoder.sv
  - src/keyboard_top.sv
  - target: test
    files:
      - tb/keyboard_properties.sv
      - tb/tb_keyboard.sv

// File: common/kbd_pkg.sv
package kbd_pkg;

    typedef logic [7:0] scan_code_t;  // One raw byte from the keyboard

    // One key action as seen by the consumer
    typedef struct packed {
        scan_code_t scan;      // Scan code without prefixes
        logic [7:0] ascii;     // Zero when unmapped or extended
        logic       released;  // Came from an F0 break sequence
        logic       extended;  // E0 prefix preceded the code
    } key_event_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_EXT,
        DEC_BREAK,
        DEC_EXT_BREAK
    } dec_state_e;

    localparam scan_code_t BREAK_PREFIX = 8'hF0;
    localparam scan_code_t EXT_PREFIX   = 8'hE0;

    // Set-2 make codes to upper-case ASCII
    function automatic logic [7:0] scan_to_ascii(scan_code_t code);
        logic [7:0] ascii;
        case (code)
            8'h1C: ascii = 8'h41;  // A
            8'h32: ascii = 8'h42;  // B
            8'h21: ascii = 8'h43;  // C
            8'h23: ascii = 8'h44;  // D
            8'h24: ascii = 8'h45;  // E
            8'h2B: ascii = 8'h46;  // F
            8'h34: ascii = 8'h47;  // G
            8'h33: ascii = 8'h48;  // H
            8'h43: ascii = 8'h49;  // I
            8'h3B: ascii = 8'h4A;  // J
            8'h42: ascii = 8'h4B;  // K
            8'h4B: ascii = 8'h4C;  // L
            8'h3A: ascii = 8'h4D;  // M
            8'h31: ascii = 8'h4E;  // N
            8'h44: ascii = 8'h4F;  // O
            8'h4D: ascii = 8'h50;  // P
            8'h15: ascii = 8'h51;  // Q
            8'h2D: ascii = 8'h52;  // R
            8'h1B: ascii = 8'h53;  // S
            8'h2C: ascii = 8'h54;  // T
            8'h3C: ascii = 8'h55;  // U
            8'h2A: ascii = 8'h56;  // V
            8'h1D: ascii = 8'h57;  // W
            8'h22: ascii = 8'h58;  // X
            8'h35: ascii = 8'h59;  // Y
            8'h1A: ascii = 8'h5A;  // Z
            8'h45: ascii = 8'h30;  // 0
            8'h16: ascii = 8'h31;  // 1
            8'h1E: ascii = 8'h32;  // 2
            8'h26: ascii = 8'h33;  // 3
            8'h25: ascii = 8'h34;  // 4
            8'h2E: ascii = 8'h35;  // 5
            8'h36: ascii = 8'h36;  // 6
            8'h3D: ascii = 8'h37;  // 7
            8'h3E: ascii = 8'h38;  // 8
            8'h46: ascii = 8'h39;  // 9
            8'h29: ascii = 8'h20;  // Space
            8'h5A: ascii = 8'h0D;  // Enter
            default: ascii = 8'h00;
        endcase
        return ascii;
    endfunction

endpackage

// File: ps2/ps2_rx.sv
`timescale 1ns/1ns

module ps2_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::scan_code_t code,
    output logic                code_valid,
    output logic                frame_err
);

    logic [2:0]          clk_sync;   // Two sync flops plus edge register
    logic [1:0]          data_sync;
    logic                fall;
    logic                data_bit;
    kbd_pkg::rx_state_e  state;
    logic [2:0]          bit_cnt;
    kbd_pkg::scan_code_t shift;
    logic                start_bit;
    logic                parity_bit;
    logic                frame_ok;

    assign fall     = clk_sync[2] & ~clk_sync[1];  // Falling edge of PS/2 clock
    assign data_bit = data_sync[1];                 // Aligned with clk_sync[1]

    // Start low, stop high (current bit), odd parity over data and parity bit
    assign frame_ok = ~start_bit & data_bit & (^{shift, parity_bit});

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync   <= '1;  // Lines idle high
            data_sync  <= '1;
            state      <= kbd_pkg::RX_IDLE;
            bit_cnt    <= '0;
            code_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[1:0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    kbd_pkg::RX_IDLE: begin
                        bit_cnt <= '0;
                        state   <= kbd_pkg::RX_DATA;
                    end
                    kbd_pkg::RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= kbd_pkg::RX_PARITY;
                    end
                    kbd_pkg::RX_PARITY: begin
                        state <= kbd_pkg::RX_STOP;
                    end
                    kbd_pkg::RX_STOP: begin
                        state <= kbd_pkg::RX_IDLE;
                        if (frame_ok)
                            code_valid <= 1'b1;
                        else
                            frame_err <= 1'b1;  // Sticky until reset
                    end
                    default: state <= kbd_pkg::RX_IDLE;
                endcase
            end
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (fall) begin
            case (state)
                kbd_pkg::RX_IDLE:   start_bit  <= data_bit;
                kbd_pkg::RX_DATA:   shift      <= {data_bit, shift[7:1]};  // LSB first
                kbd_pkg::RX_PARITY: parity_bit <= data_bit;
                kbd_pkg::RX_STOP: begin
                    if (frame_ok)
                        code <= shift;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: ps2/scan_fifo.sv
`timescale 1ns/1ns

module scan_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::scan_code_t code,
    input  logic                code_valid,
    input  logic                pop,
    output kbd_pkg::scan_code_t head,
    output logic                not_empty,
    output logic                overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    kbd_pkg::scan_code_t mem [FIFO_DEPTH];
    logic [AW:0]         wr_ptr;  // Extra bit tells full from empty
    logic [AW:0]         rd_ptr;
    logic                full;
    logic                do_push;
    logic                do_pop;

    assign not_empty = (wr_ptr != rd_ptr);
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_pop    = pop && not_empty;
    assign do_push   = code_valid && (!full || do_pop);  // Pop frees a slot this cycle

    assign head = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (code_valid && !do_push)
                overflow <= 1'b1;  // Byte dropped, sticky
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= code;
    end

endmodule

// File: src/key_decoder.sv
`timescale 1ns/1ns

module key_decoder #(
    parameter int CREDITS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::scan_code_t head,
    input  logic                not_empty,
    output logic                pop,
    output kbd_pkg::key_event_t evt,
    output logic                evt_valid,
    input  logic                evt_credit,
    output logic [7:0]          release_count
);

    localparam int CW = $clog2(CREDITS + 1);

    kbd_pkg::dec_state_e state;
    kbd_pkg::dec_state_e state_next;
    logic [CW-1:0]       credit_cnt;
    logic [CW-1:0]       credit_next;
    logic                is_ext_prefix;
    logic                is_break_prefix;
    logic                is_prefix;
    logic                tag_ext;
    logic                tag_rel;
    logic                emit;
    kbd_pkg::key_event_t evt_next;

    assign is_ext_prefix   = (head == kbd_pkg::EXT_PREFIX);
    assign is_break_prefix = (head == kbd_pkg::BREAK_PREFIX);
    assign is_prefix       = is_ext_prefix || is_break_prefix;

    assign tag_ext = (state == kbd_pkg::DEC_EXT) || (state == kbd_pkg::DEC_EXT_BREAK);
    assign tag_rel = (state == kbd_pkg::DEC_BREAK) || (state == kbd_pkg::DEC_EXT_BREAK);

    // An event already in evt holds one credit not yet taken from the count
    assign pop  = not_empty && (credit_cnt > CW'(evt_valid));
    assign emit = pop && !is_prefix;

    // Prefixes accumulate, any other byte closes the sequence
    always_comb begin
        state_next = kbd_pkg::DEC_IDLE;
        if (is_ext_prefix)
            state_next = tag_rel ? kbd_pkg::DEC_EXT_BREAK : kbd_pkg::DEC_EXT;
        else if (is_break_prefix)
            state_next = tag_ext ? kbd_pkg::DEC_EXT_BREAK : kbd_pkg::DEC_BREAK;
    end

    always_comb begin
        evt_next.scan     = head;
        evt_next.ascii    = tag_ext ? 8'h00 : kbd_pkg::scan_to_ascii(head);  // No map for E0 keys
        evt_next.released = tag_rel;
        evt_next.extended = tag_ext;
    end

    always_comb begin
        credit_next = credit_cnt;
        if (evt_valid && !evt_credit)
            credit_next = credit_cnt - 1'b1;
        else if (evt_credit && !evt_valid && credit_cnt != CW'(CREDITS))
            credit_next = credit_cnt + 1'b1;  // Saturate at CREDITS
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= kbd_pkg::DEC_IDLE;
            credit_cnt    <= CW'(CREDITS);
            evt_valid     <= 1'b0;
            release_count <= 8'd0;
        end else begin
            credit_cnt <= credit_next;
            evt_valid  <= emit;
            if (pop)
                state <= state_next;  // Held while waiting for credits
            if (emit && tag_rel)
                release_count <= release_count + 8'd1;  // Wraps
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (emit)
            evt <= evt_next;
    end

endmodule

// File: src/keyboard_top.sv
`timescale 1ns/1ns

module keyboard_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int CREDITS    = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::key_event_t evt,
    output logic                evt_valid,
    input  logic                evt_credit,
    output logic [7:0]          release_count,
    output logic                overflow,
    output logic                frame_err
);

    kbd_pkg::scan_code_t code;
    logic                code_valid;
    kbd_pkg::scan_code_t head;
    logic                not_empty;
    logic                pop;

    ps2_rx rx_i (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid),
        .frame_err  (frame_err)
    );

    scan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .rst        (rst),
        .code       (code),
        .code_valid (code_valid),
        .pop        (pop),
        .head       (head),
        .not_empty  (not_empty),
        .overflow   (overflow)
    );

    key_decoder #(
        .CREDITS (CREDITS)
    ) dec_i (
        .clk           (clk),
        .rst           (rst),
        .head          (head),
        .not_empty     (not_empty),
        .pop           (pop),
        .evt           (evt),
        .evt_valid     (evt_valid),
        .evt_credit    (evt_credit),
        .release_count (release_count)
    );

endmodule

// File: tb.f
common/kbd_pkg.sv
ps2/ps2_rx.sv
ps2/scan_fifo.sv
src/key_decoder.sv
src/keyboard_top.sv
tb/keyboard_properties.sv
tb/tb_keyboard.sv

// File: tb/keyboard_properties.sv
`timescale 1ns/1ns

module keyboard_properties #(
    parameter int CREDITS = 4,
    parameter int CW      = 3
) (
    input logic                clk,
    input logic                rst,
    input kbd_pkg::scan_code_t head,
    input logic                not_empty,
    input logic                pop,
    input logic                evt_valid,
    input logic [CW-1:0]       credit_cnt
);

    int fail_count = 0;  // Assertion failures so far

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CW'(CREDITS))
        else begin
            fail_count++;
            $error("Credit count above its limit");
        end

    event_needs_credit: assert property (@(posedge clk) disable iff (rst)
        evt_valid |-> credit_cnt != '0)
        else begin
            fail_count++;
            $error("Key event issued with no credit left");
        end

    // A pop must take a byte that the FIFO really holds
    pop_needs_data: assert property (@(posedge clk) disable iff (rst)
        pop |-> not_empty && !$isunknown(head))
        else begin
            fail_count++;
            $error("FIFO popped while empty or with an unknown byte at its head");
        end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !evt_valid)
        else begin
            fail_count++;
            $error("Key event valid right after reset");
        end

endmodule

bind key_decoder keyboard_properties #(
    .CREDITS (CREDITS),
    .CW      (CW)
) props_i (
    .clk        (clk),
    .rst        (rst),
    .head       (head),
    .not_empty  (not_empty),
    .pop        (pop),
    .evt_valid  (evt_valid),
    .credit_cnt (credit_cnt)
);

// File: tb/tb_keyboard.sv
`timescale 1ns/1ns

module tb_keyboard;

    localparam int FIFO_DEPTH = 8;
    localparam int CREDITS    = 4;
    localparam int HALF_BIT   = 5;   // clk cycles per PS/2 half bit
    localparam int DRIVE_DLY  = 10;  // ns after the rising edge
    localparam int NUM_ROWS   = 38;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 11 * 10 * 3;

    typedef struct packed {
        logic [3:0]          test;
        kbd_pkg::scan_code_t data;
        logic                bad;   // Force wrong parity
    } stim_row_t;

    // Test number, byte sent by the device, bad parity
    localparam stim_row_t STIM [NUM_ROWS] = '{
        '{4'd1, 8'h1C, 1'b0}, '{4'd1, 8'h45, 1'b0}, '{4'd1, 8'h16, 1'b0},
        '{4'd1, 8'h29, 1'b0}, '{4'd1, 8'h5A, 1'b0}, '{4'd1, 8'h76, 1'b0},
        '{4'd1, 8'h1A, 1'b0},
        '{4'd2, 8'hF0, 1'b0}, '{4'd2, 8'h1C, 1'b0}, '{4'd2, 8'hF0, 1'b0},
        '{4'd2, 8'h16, 1'b0},
        '{4'd3, 8'hE0, 1'b0}, '{4'd3, 8'h75, 1'b0}, '{4'd3, 8'hE0, 1'b0},
        '{4'd3, 8'hF0, 1'b0}, '{4'd3, 8'h75, 1'b0},
        '{4'd4, 8'h24, 1'b1}, '{4'd4, 8'h32, 1'b0}, '{4'd4, 8'h21, 1'b0},
        '{4'd5, 8'h1C, 1'b0}, '{4'd5, 8'h32, 1'b0}, '{4'd5, 8'h21, 1'b0},
        '{4'd5, 8'h23, 1'b0}, '{4'd5, 8'h24, 1'b0}, '{4'd5, 8'h2B, 1'b0},
        '{4'd6, 8'h34, 1'b0}, '{4'd6, 8'h33, 1'b0}, '{4'd6, 8'h43, 1'b0},
        '{4'd6, 8'h3B, 1'b0}, '{4'd6, 8'h42, 1'b0}, '{4'd6, 8'h4B, 1'b0},
        '{4'd6, 8'h3A, 1'b0}, '{4'd6, 8'h31, 1'b0}, '{4'd6, 8'h44, 1'b0},
        '{4'd6, 8'h4D, 1'b0}, '{4'd6, 8'h15, 1'b0}, '{4'd6, 8'h2D, 1'b0},
        '{4'd6, 8'h1B, 1'b0}
    };

    // Scan code in the upper byte, ASCII in the lower byte
    localparam logic [15:0] ASCII_MAP [38] = '{
        16'h1C41, 16'h3242, 16'h2143, 16'h2344, 16'h2445, 16'h2B46, 16'h3447, 16'h3348,
        16'h4349, 16'h3B4A, 16'h424B, 16'h4B4C, 16'h3A4D, 16'h314E, 16'h444F, 16'h4D50,
        16'h1551, 16'h2D52, 16'h1B53, 16'h2C54, 16'h3C55, 16'h2A56, 16'h1D57, 16'h2258,
        16'h3559, 16'h1A5A, 16'h4530, 16'h1631, 16'h1E32, 16'h2633, 16'h2534, 16'h2E35,
        16'h3636, 16'h3D37, 16'h3E38, 16'h4639, 16'h2920, 16'h5A0D
    };

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_data;
    kbd_pkg::key_event_t evt;
    logic                evt_valid;
    logic                evt_credit;
    logic [7:0]          release_count;
    logic                overflow;
    logic                frame_err;

    kbd_pkg::key_event_t exp_q[$];
    int                  pending;     // Events not yet paid back with a credit
    int                  evt_seen;
    logic                hold;        // Consumer withholds credits
    logic [7:0]          exp_rel;
    logic [31:0]         rng_state;

    keyboard_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .evt           (evt),
        .evt_valid     (evt_valid),
        .evt_credit    (evt_credit),
        .release_count (release_count),
        .overflow      (overflow),
        .frame_err     (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [7:0] expected_ascii(input kbd_pkg::scan_code_t code);
        logic [7:0] result;
        result = 8'h00;  // Unmapped keys
        foreach (ASCII_MAP[i])
            if (ASCII_MAP[i][15:8] == code)
                result = ASCII_MAP[i][7:0];
        return result;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_event(input kbd_pkg::key_event_t got, input kbd_pkg::key_event_t exp);
        if (got !== exp)
            stop_on_error($sformatf(
                "Error at %0t: event scan %h ascii %h rel %b ext %b, expected %h %h %b %b",
                $time, got.scan, got.ascii, got.released, got.extended,
                exp.scan, exp.ascii, exp.released, exp.extended));
    endtask

    task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s is %0d, expected %0d",
                                    $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s is %b, expected %b",
                                    $time, what, got, exp));
    endtask

    // Data changes while the PS/2 clock is high
    task automatic send_frame(input kbd_pkg::scan_code_t data, input logic bad);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ bad, data, 1'b0};
        for (int b = 0; b < 11; b++) begin
            ps2_data = frame[b];
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b1;
        end
        wait_cycles(2 * HALF_BIT);  // Idle gap
    endtask

    task automatic run_test(input int t);
        logic                ext;
        logic                rel;
        int                  makes;
        int                  seen_at_start;
        kbd_pkg::key_event_t e;
        ext = 1'b0;
        rel = 1'b0;
        makes = 0;
        seen_at_start = evt_seen;
        hold = (t >= 5);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (STIM[i].test == 4'(t)) begin
                if (!STIM[i].bad) begin
                    if (STIM[i].data == 8'hE0) begin
                        ext = 1'b1;
                    end else if (STIM[i].data == 8'hF0) begin
                        rel = 1'b1;
                    end else begin
                        e.scan     = STIM[i].data;
                        e.ascii    = ext ? 8'h00 : expected_ascii(STIM[i].data);
                        e.released = rel;
                        e.extended = ext;
                        if (!hold || makes < CREDITS + FIFO_DEPTH) begin  // Else dropped
                            exp_q.push_back(e);
                            if (rel)
                                exp_rel = exp_rel + 8'd1;
                        end
                        makes++;
                        ext = 1'b0;
                        rel = 1'b0;
                    end
                end
                send_frame(STIM[i].data, STIM[i].bad);
            end
        end
        if (hold) begin
            wait_cycles(20);
            check_count("events while credits withheld", 8'(evt_seen - seen_at_start),
                        8'((makes < CREDITS) ? makes : CREDITS));
            check_flag("overflow", overflow, makes > CREDITS + FIFO_DEPTH);
            hold = 1'b0;
        end
        while (exp_q.size() != 0 || pending != 0)
            wait_cycles(1);
        wait_cycles(20);  // Room for any stray event
        check_count("release_count", release_count, exp_rel);
        check_flag("frame_err", frame_err, t >= 4);
        check_flag("overflow", overflow, t >= 6);
    endtask

    // Event monitor
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && evt_valid) begin
                if (exp_q.size() == 0)
                    stop_on_error("A key event arrived when none was expected");
                else
                    check_event(evt, exp_q.pop_front());
                evt_seen++;
                pending++;
            end
        end
    end

    // Failures of the bound decoder assertions
    initial begin
        wait (dut_i.dec_i.props_i.fail_count != 0);
        stop_on_error("A decoder assertion failed");
    end

    // Consumer pays back one credit per event after a random delay
    initial begin
        forever begin
            wait_cycles(1);
            evt_credit = 1'b0;
            if (!hold && pending > 0) begin
                rng_state = xorshift32(rng_state);
                wait_cycles(1 + int'(rng_state % 4));
                evt_credit = 1'b1;
                pending--;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: no key event or completion after %0d cycles, the run hung",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst        = 1'b1;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        evt_credit = 1'b0;
        hold       = 1'b0;
        pending    = 0;
        evt_seen   = 0;
        exp_rel    = 8'd0;
        rng_state  = 32'd4162;
        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        wait_cycles(5);
        for (int t = 1; t <= 6; t++)
            run_test(t);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
